// ==== rtl/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  logic              rsp_valid_q;
  soc_pkg::bus_rsp_t rsp_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Word select from addr[5:3], image wraps inside the window
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.we) begin
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end else begin
        rsp_q.rdata <= soc_pkg::boot_image[req_i.addr[5:3]];
        rsp_q.err   <= 1'b0;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== rtl/bus_demux.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_demux (
  input  logic                                     clk_i,
  input  logic                                     ndmreset_n,
  input  logic                                     req_valid_i,
  input  soc_pkg::bus_req_t                        req_i,
  output logic                                     rsp_valid_o,
  output soc_pkg::bus_rsp_t                        rsp_o,
  output logic [`SOC_NUM_TGT-1:0]                  tgt_req_valid_o,
  output soc_pkg::bus_req_t                        tgt_req_o,
  input  logic [`SOC_NUM_TGT-1:0]                  tgt_rsp_valid_i,
  input  soc_pkg::bus_rsp_t [`SOC_NUM_TGT-1:0]     tgt_rsp_i
);

  soc_pkg::tgt_e          hit_tgt;
  logic [`SOC_ADDR_W-1:0] hit_base;

  soc_pkg::tgt_e sel_q;
  logic          busy_q;
  logic          miss_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    hit_tgt  = soc_pkg::TGT_NONE;
    hit_base = '0;
    for (int i = 0; i < `SOC_NUM_TGT; i++) begin
      if (req_i.addr >= soc_pkg::addr_map[i].start_addr &&
          req_i.addr <  soc_pkg::addr_map[i].end_addr) begin
        hit_tgt  = soc_pkg::addr_map[i].idx;
        hit_base = soc_pkg::addr_map[i].start_addr;
      end
    end
  end

  // Shared request bus, only the strobe is steered
  always_comb begin
    tgt_req_o       = req_i;
    tgt_req_o.addr  = req_i.addr - hit_base;
    tgt_req_valid_o = '0;
    if (req_valid_i && hit_tgt != soc_pkg::TGT_NONE) begin
      tgt_req_valid_o[hit_tgt] = 1'b1;
    end
  end

  // ----------------------------------------
  // Outstanding request tracking
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sel_q  <= soc_pkg::TGT_NONE;
      busy_q <= 1'b0;
      miss_q <= 1'b0;
    end else begin
      miss_q <= req_valid_i && hit_tgt == soc_pkg::TGT_NONE;
      if (rsp_valid_o) begin
        busy_q <= 1'b0;
      end
      if (req_valid_i) begin
        sel_q  <= hit_tgt;
        busy_q <= 1'b1;
      end
    end
  end

  // Only the owner of the outstanding request may answer
  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b1;
    if (miss_q) begin
      rsp_valid_o = 1'b1;
    end else if (busy_q && sel_q != soc_pkg::TGT_NONE) begin
      rsp_valid_o = tgt_rsp_valid_i[sel_q];
      rsp_o       = tgt_rsp_i[sel_q];
    end
  end

endmodule

// ==== rtl/clint_timer.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module clint_timer (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic [1:0]             rtc_sync_q;
  logic                   rtc_prev_q;
  logic                   rtc_toggle_q;
  logic                   rtc_rise;
  logic                   mtime_tick;
  logic [`SOC_DATA_W-1:0] mtime_q;
  logic [`SOC_DATA_W-1:0] mtimecmp_q;
  logic                   msip_q;
  logic                   rsp_valid_q;
  soc_pkg::bus_rsp_t      rsp_q;

  // ----------------------------------------
  // RTC time base
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q   <= '0;
      rtc_prev_q   <= 1'b0;
      rtc_toggle_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_toggle_q <= ~rtc_toggle_q;
      end
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // Toggle about to go high, so half the rtc rate
  assign mtime_tick = rtc_rise & ~rtc_toggle_q;

  // ----------------------------------------
  // Registers, bus writes win over the tick
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      if (mtime_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_valid_i && req_i.we) begin
        case (req_i.addr)
          `CLINT_MSIP_OFS:     msip_q     <= req_i.wdata[0];
          `CLINT_MTIMECMP_OFS: mtimecmp_q <= req_i.wdata;
          `CLINT_MTIME_OFS:    mtime_q    <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Read data, unknown offsets answer with err
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b0;
      case (req_i.addr)
        `CLINT_MSIP_OFS:     rsp_q.rdata <= {{(`SOC_DATA_W-1){1'b0}}, msip_q};
        `CLINT_MTIMECMP_OFS: rsp_q.rdata <= mtimecmp_q;
        `CLINT_MTIME_OFS:    rsp_q.rdata <= mtime_q;
        default:             rsp_q.err   <= 1'b1;
      endcase
      if (req_i.we) begin
        rsp_q.rdata <= '0;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

// ==== rtl/debug_req_gate.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`DMI_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // Gives boot code a head start before debug can halt the hart
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_W'(`DMI_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_req_i;

endmodule

// ==== rtl/reg_slice.sv ====
`timescale 1ns/1ps

module reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with its strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== rtl/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define SOC_ADDR_W 32
`define SOC_DATA_W 64

// Number of mapped targets behind the demux
`define SOC_NUM_TGT 3

// ----------------------------------------
// Address map
// ----------------------------------------
`define ROM_BASE     32'h0001_0000
`define ROM_LEN      32'h0000_0100
`define CLINT_BASE   32'h0200_0000
`define CLINT_LEN    32'h0000_C000
`define CLUSTER_BASE 32'h1000_0000
`define CLUSTER_LEN  32'h0040_0000

// CLINT register offsets, relative to CLINT_BASE
`define CLINT_MSIP_OFS     32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS    32'h0000_BFF8

// Debug hold-off after reset, in clk_i cycles
`define DMI_DELAY_CYCLES 500

`define BOOT_WORDS 8

`endif

// ==== rtl/soc_pkg.sv ====
`include "soc_macros.svh"

package soc_pkg;

  // Request from the single bus master
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

  // Target index, also the slot in the per-target strobe vectors
  typedef enum logic [1:0] {
    TGT_ROM     = 2'd0,
    TGT_CLINT   = 2'd1,
    TGT_CLUSTER = 2'd2,
    TGT_NONE    = 2'd3
  } tgt_e;

  // End address is exclusive
  typedef struct packed {
    tgt_e                   idx;
    logic [`SOC_ADDR_W-1:0] start_addr;
    logic [`SOC_ADDR_W-1:0] end_addr;
  } addr_rule_t;

  localparam addr_rule_t addr_map [`SOC_NUM_TGT] = '{
    '{idx: TGT_ROM, start_addr: `ROM_BASE, end_addr: `ROM_BASE + `ROM_LEN},
    '{idx: TGT_CLINT, start_addr: `CLINT_BASE, end_addr: `CLINT_BASE + `CLINT_LEN},
    '{idx: TGT_CLUSTER, start_addr: `CLUSTER_BASE, end_addr: `CLUSTER_BASE + `CLUSTER_LEN}
  };

  // Boot image, one entry per 64-bit ROM word
  localparam logic [`SOC_DATA_W-1:0] boot_image [`BOOT_WORDS] = '{
    64'h0202_8593_0000_0297,
    64'hF140_2573_0182_B283,
    64'h1050_0073_0002_8067,
    64'h0000_0000_0000_0013,
    64'h8000_0000_0000_0000,
    64'h0000_0000_0001_0040,
    64'hDEAD_BEEF_CAFE_F00D,
    64'h0000_0000_0000_0000
  };

endpackage

// ==== rtl/soc_subsystem.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_subsystem (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  logic              debug_req_i,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              cluster_req_valid_o,
  output soc_pkg::bus_req_t cluster_req_o,
  input  logic              cluster_rsp_valid_i,
  input  soc_pkg::bus_rsp_t cluster_rsp_i,
  output logic              timer_irq_o,
  output logic              ipi_o,
  output logic              debug_req_o
);

  logic [`SOC_NUM_TGT-1:0]                 tgt_req_valid;
  soc_pkg::bus_req_t                       tgt_req;
  logic [`SOC_NUM_TGT-1:0]                 tgt_rsp_valid;
  soc_pkg::bus_rsp_t [`SOC_NUM_TGT-1:0]    tgt_rsp;

  bus_demux i_bus_demux (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .req_valid_i     ( req_valid_i   ),
    .req_i           ( req_i         ),
    .rsp_valid_o     ( rsp_valid_o   ),
    .rsp_o           ( rsp_o         ),
    .tgt_req_valid_o ( tgt_req_valid ),
    .tgt_req_o       ( tgt_req       ),
    .tgt_rsp_valid_i ( tgt_rsp_valid ),
    .tgt_rsp_i       ( tgt_rsp       )
  );

  // ----------------------------------------
  // Local targets
  // ----------------------------------------
  boot_rom i_boot_rom (
    .clk_i       ( clk_i                                ),
    .ndmreset_n  ( ndmreset_n                           ),
    .req_valid_i ( tgt_req_valid[soc_pkg::TGT_ROM]      ),
    .req_i       ( tgt_req                              ),
    .rsp_valid_o ( tgt_rsp_valid[soc_pkg::TGT_ROM]      ),
    .rsp_o       ( tgt_rsp[soc_pkg::TGT_ROM]            )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i                                ),
    .ndmreset_n  ( ndmreset_n                           ),
    .rtc_i       ( rtc_i                                ),
    .req_valid_i ( tgt_req_valid[soc_pkg::TGT_CLINT]    ),
    .req_i       ( tgt_req                              ),
    .rsp_valid_o ( tgt_rsp_valid[soc_pkg::TGT_CLINT]    ),
    .rsp_o       ( tgt_rsp[soc_pkg::TGT_CLINT]          ),
    .timer_irq_o ( timer_irq_o                          ),
    .ipi_o       ( ipi_o                                )
  );

  // ----------------------------------------
  // Cluster port, one cut each way
  // ----------------------------------------
  reg_slice #(
    .payload_t ( soc_pkg::bus_req_t )
  ) i_cluster_req_slice (
    .clk_i      ( clk_i                                ),
    .ndmreset_n ( ndmreset_n                           ),
    .valid_i    ( tgt_req_valid[soc_pkg::TGT_CLUSTER]  ),
    .data_i     ( tgt_req                              ),
    .valid_o    ( cluster_req_valid_o                  ),
    .data_o     ( cluster_req_o                        )
  );

  reg_slice #(
    .payload_t ( soc_pkg::bus_rsp_t )
  ) i_cluster_rsp_slice (
    .clk_i      ( clk_i                                ),
    .ndmreset_n ( ndmreset_n                           ),
    .valid_i    ( cluster_rsp_valid_i                  ),
    .data_i     ( cluster_rsp_i                        ),
    .valid_o    ( tgt_rsp_valid[soc_pkg::TGT_CLUSTER]  ),
    .data_o     ( tgt_rsp[soc_pkg::TGT_CLUSTER]        )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, the simulation log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_subsystem \
  -f soc_subsystem.f -o tb_soc_subsystem > build.log 2>&1 \
  && ./obj_dir/tb_soc_subsystem > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

// ==== soc_subsystem.f ====
+incdir+rtl
rtl/soc_pkg.sv
rtl/reg_slice.sv
rtl/bus_demux.sv
rtl/boot_rom.sv
rtl/clint_timer.sv
rtl/debug_req_gate.sv
rtl/soc_subsystem.sv
verification/soc_subsystem_asserts.sv
verification/tb_soc_subsystem.sv

// ==== verification/soc_subsystem_asserts.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_subsystem_asserts (
  input logic                    clk_i,
  input logic                    ndmreset_n,
  input logic                    req_valid_i,
  input logic                    rsp_valid_i,
  input logic [`SOC_NUM_TGT-1:0] tgt_rsp_valid_i,
  input soc_pkg::tgt_e           hit_tgt_i
);

  logic pending_q;

  // Tracks the single request in flight
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pending_q <= 1'b0;
    end else if (req_valid_i) begin
      pending_q <= 1'b1;
    end else if (rsp_valid_i) begin
      pending_q <= 1'b0;
    end
  end

  no_overlap: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_valid_i |-> !pending_q)
    else $error("second request issued before the response to the first");

  no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (|tgt_rsp_valid_i) |-> pending_q)
    else $error("target response strobe with no request outstanding");

  // ROM and decode miss answer in the next cycle
  fixed_latency: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_valid_i && (hit_tgt_i == soc_pkg::TGT_ROM || hit_tgt_i == soc_pkg::TGT_NONE)
    |=> rsp_valid_i)
    else $error("ROM or decode-miss response not one cycle after the request");

endmodule

bind bus_demux soc_subsystem_asserts i_demux_asserts (
  .clk_i           ( clk_i           ),
  .ndmreset_n      ( ndmreset_n      ),
  .req_valid_i     ( req_valid_i     ),
  .rsp_valid_i     ( rsp_valid_o     ),
  .tgt_rsp_valid_i ( tgt_rsp_valid_i ),
  .hit_tgt_i       ( hit_tgt         )
);

// ==== verification/tb_soc_subsystem.sv ====
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_subsystem;

  localparam int CLK_PERIOD  = 8;
  localparam int N_RANDOM    = 48;
  localparam int NUM_TXN     = N_RANDOM + 16;
  localparam int MAX_DLY     = 7;
  localparam int RSP_TIMEOUT = MAX_DLY + 8;
  localparam int RTC_HOLD    = 4;
  // Up to 2*6 rtc rising edges with a high and a low phase each
  localparam int RTC_CYCLES  = 2 * 6 * 2 * RTC_HOLD;
  localparam int WDOG_CYCLES =
    2 * (NUM_TXN * (MAX_DLY + 4) + `DMI_DELAY_CYCLES + RTC_CYCLES);

  logic              clk_i;
  logic              ndmreset_n;
  logic              rtc_i;
  logic              debug_req_i;
  logic              req_valid_i;
  soc_pkg::bus_req_t req_i;
  logic              rsp_valid_o;
  soc_pkg::bus_rsp_t rsp_o;
  logic              cluster_req_valid_o;
  soc_pkg::bus_req_t cluster_req_o;
  logic              cluster_rsp_valid_i;
  soc_pkg::bus_rsp_t cluster_rsp_i;
  logic              timer_irq_o;
  logic              ipi_o;
  logic              debug_req_o;

  int unsigned err_val   = 0;
  int unsigned err_other = 0;
  int unsigned dbg_edges = 0;
  logic [31:0] lfsr_q;

  // Cluster responder state
  int unsigned       cluster_delay = 0;
  int unsigned       seen_cnt      = 0;
  soc_pkg::bus_req_t seen_req;
  logic [63:0]       cluster_mem [logic [31:0]];

  // Reference model
  logic [63:0] cluster_model [logic [31:0]];
  logic [63:0] mtime_m;
  logic [63:0] mtimecmp_m;
  logic        msip_m;
  logic        toggle_m;

  soc_subsystem i_dut (
    .clk_i               ( clk_i               ),
    .ndmreset_n          ( ndmreset_n          ),
    .rtc_i               ( rtc_i               ),
    .debug_req_i         ( debug_req_i         ),
    .req_valid_i         ( req_valid_i         ),
    .req_i               ( req_i               ),
    .rsp_valid_o         ( rsp_valid_o         ),
    .rsp_o               ( rsp_o               ),
    .cluster_req_valid_o ( cluster_req_valid_o ),
    .cluster_req_o       ( cluster_req_o       ),
    .cluster_rsp_valid_i ( cluster_rsp_valid_i ),
    .cluster_rsp_i       ( cluster_rsp_i       ),
    .timer_irq_o         ( timer_irq_o         ),
    .ipi_o               ( ipi_o               ),
    .debug_req_o         ( debug_req_o         )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Content of cluster words never written
  function automatic logic [63:0] mem_fill(input logic [31:0] a);
    return {a ^ 32'hA5A5_5A5A, ~a};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("error %s: expected 0x%h, actual 0x%h", name, exp, act);
      err_val++;
    end
  endtask

  // Starts and ends at a falling edge
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [63:0] wdata,
                            output soc_pkg::bus_rsp_t rsp);
    int waited;
    waited      = 0;
    req_i.addr  = addr;
    req_i.we    = we;
    req_i.wdata = wdata;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (!rsp_valid_o && waited < RSP_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (rsp_valid_o) else begin
      $display("no response to the request at address 0x%h", addr);
      err_other++;
    end
    rsp = rsp_o;
    @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Per-target tests
  // ----------------------------------------
  task automatic rom_read_test();
    soc_pkg::bus_rsp_t rsp;
    logic [31:0]       off;
    off = {24'b0, 5'(rand_bits(5)), 3'b0};
    bus_access(`ROM_BASE + off, 1'b0, 64'h0, rsp);
    check_eq("rom_read", soc_pkg::boot_image[off[5:3]], rsp.rdata);
    check_eq("rom_err", 64'h0, 64'(rsp.err));
  endtask

  task automatic cluster_test();
    soc_pkg::bus_rsp_t rsp;
    logic [31:0]       off;
    logic              we;
    logic [63:0]       wd;
    logic [63:0]       exp;
    int unsigned       cnt0;
    // Few distinct words so that reads hit earlier writes
    off           = {10'b0, 3'(rand_bits(3)), 14'b0, 2'(rand_bits(2)), 3'b0};
    we            = 1'(rand_bits(1));
    wd            = rand_bits(64);
    cluster_delay = 32'(rand_bits(3));
    cnt0          = seen_cnt;
    bus_access(`CLUSTER_BASE + off, we, wd, rsp);
    check_eq("cluster_req_count", 64'(cnt0 + 1), 64'(seen_cnt));
    check_eq("cluster_req_addr", 64'(off), 64'(seen_req.addr));
    check_eq("cluster_req_we", 64'(we), 64'(seen_req.we));
    check_eq("cluster_rsp_err", 64'h0, 64'(rsp.err));
    if (we) begin
      check_eq("cluster_req_wdata", wd, seen_req.wdata);
      cluster_model[off] = wd;
    end else begin
      exp = cluster_model.exists(off) ? cluster_model[off] : mem_fill(off);
      check_eq("cluster_read", exp, rsp.rdata);
    end
  endtask

  task automatic miss_test();
    soc_pkg::bus_rsp_t rsp;
    logic [31:0]       addr;
    logic              we;
    logic [63:0]       wd;
    int unsigned       cnt0;
    case (2'(rand_bits(2)))
      2'd0:    addr = `ROM_BASE + `ROM_LEN;
      2'd1:    addr = `CLINT_BASE + `CLINT_LEN;
      2'd2:    addr = `CLUSTER_BASE + `CLUSTER_LEN;
      default: addr = 32'h8000_0000 | 32'(rand_bits(31));
    endcase
    we   = 1'(rand_bits(1));
    wd   = rand_bits(64);
    cnt0 = seen_cnt;
    bus_access(addr, we, wd, rsp);
    check_eq("miss_rdata", 64'h0, rsp.rdata);
    check_eq("miss_err", 64'h1, 64'(rsp.err));
    check_eq("miss_no_cluster_req", 64'(cnt0), 64'(seen_cnt));
  endtask

  task automatic clint_reg_test();
    soc_pkg::bus_rsp_t rsp;
    logic [63:0]       wd;
    bus_access(`CLINT_BASE + `CLINT_MSIP_OFS, 1'b1, 64'h1, rsp);
    msip_m = 1'b1;
    check_eq("clint_ipi_set", 64'(msip_m), 64'(ipi_o));
    bus_access(`CLINT_BASE + `CLINT_MSIP_OFS, 1'b0, 64'h0, rsp);
    check_eq("clint_msip_read", 64'(msip_m), rsp.rdata);
    // Only bit 0 is stored
    bus_access(`CLINT_BASE + `CLINT_MSIP_OFS, 1'b1, 64'h2, rsp);
    msip_m = 1'b0;
    check_eq("clint_ipi_clear", 64'(msip_m), 64'(ipi_o));
    wd = rand_bits(32);
    bus_access(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b1, wd, rsp);
    mtime_m = wd;
    bus_access(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b0, 64'h0, rsp);
    check_eq("clint_mtime_read", mtime_m, rsp.rdata);
    wd = rand_bits(63) | 64'h8000_0000_0000_0000;
    bus_access(`CLINT_BASE + `CLINT_MTIMECMP_OFS, 1'b1, wd, rsp);
    mtimecmp_m = wd;
    bus_access(`CLINT_BASE + `CLINT_MTIMECMP_OFS, 1'b0, 64'h0, rsp);
    check_eq("clint_mtimecmp_read", mtimecmp_m, rsp.rdata);
    check_eq("clint_timer_irq", 64'(mtime_m >= mtimecmp_m), 64'(timer_irq_o));
    // Hole inside the CLINT window
    bus_access(`CLINT_BASE + 32'h8, 1'b0, 64'h0, rsp);
    check_eq("clint_hole_err", 64'h1, 64'(rsp.err));
    check_eq("clint_hole_rdata", 64'h0, rsp.rdata);
  endtask

  task automatic timer_test();
    soc_pkg::bus_rsp_t rsp;
    int                n;
    bus_access(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b0, 64'h0, rsp);
    check_eq("timer_mtime_start", mtime_m, rsp.rdata);
    n          = 3 + int'(rand_bits(2));
    mtimecmp_m = mtime_m + 64'(n);
    bus_access(`CLINT_BASE + `CLINT_MTIMECMP_OFS, 1'b1, mtimecmp_m, rsp);
    check_eq("timer_irq_armed", 64'h0, 64'(timer_irq_o));
    for (int i = 0; i < 2 * n; i++) begin
      rtc_i = 1'b1;
      repeat (RTC_HOLD) @(negedge clk_i);
      // mtime ticks when the divide-by-two toggle rises
      toggle_m = ~toggle_m;
      if (toggle_m) begin
        mtime_m = mtime_m + 64'd1;
      end
      rtc_i = 1'b0;
      repeat (RTC_HOLD) @(negedge clk_i);
      check_eq("timer_irq_step", 64'(mtime_m >= mtimecmp_m), 64'(timer_irq_o));
    end
    check_eq("timer_irq_high", 64'h1, 64'(timer_irq_o));
    bus_access(`CLINT_BASE + `CLINT_MTIME_OFS, 1'b0, 64'h0, rsp);
    check_eq("timer_mtime_end", mtime_m, rsp.rdata);
  endtask

  // ----------------------------------------
  // Cluster memory responder
  // ----------------------------------------
  initial begin : cluster_responder
    cluster_rsp_valid_i = 1'b0;
    cluster_rsp_i       = '0;
    forever begin
      @(negedge clk_i);
      if (cluster_req_valid_o) begin
        seen_req = cluster_req_o;
        seen_cnt = seen_cnt + 1;
        repeat (cluster_delay) @(negedge clk_i);
        cluster_rsp_i.err = 1'b0;
        if (seen_req.we) begin
          cluster_mem[seen_req.addr] = seen_req.wdata;
          cluster_rsp_i.rdata        = '0;
        end else if (cluster_mem.exists(seen_req.addr)) begin
          cluster_rsp_i.rdata = cluster_mem[seen_req.addr];
        end else begin
          cluster_rsp_i.rdata = mem_fill(seen_req.addr);
        end
        cluster_rsp_valid_i = 1'b1;
        @(negedge clk_i);
        cluster_rsp_valid_i = 1'b0;
      end
    end
  end

  // Rising edges seen since reset release
  always @(posedge clk_i) begin
    if (ndmreset_n) begin
      dbg_edges <= dbg_edges + 1;
    end
  end

  // Sampled at the rising edge, before the gate counter moves
  initial begin : debug_monitor
    @(negedge clk_i);
    forever begin
      @(posedge clk_i);
      check_eq("debug_gate", 64'((dbg_edges >= `DMI_DELAY_CYCLES) && debug_req_i),
               64'(debug_req_o));
    end
  end

  initial begin : watchdog
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("errors: %0d value, %0d other", err_val, err_other + 1);
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_seq
    soc_pkg::bus_rsp_t rsp;
    lfsr_q      = 32'h5719;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    mtime_m     = '0;
    mtimecmp_m  = '1;
    msip_m      = 1'b0;
    toggle_m    = 1'b0;
    repeat (5) @(negedge clk_i);
    ndmreset_n = 1'b1;
    @(negedge clk_i);

    // Mixed traffic with cluster accesses weighted double
    for (int t = 0; t < N_RANDOM; t++) begin
      case (2'(rand_bits(2)))
        2'd0:    rom_read_test();
        2'd3:    miss_test();
        default: cluster_test();
      endcase
    end

    bus_access(`ROM_BASE + 32'h8, 1'b1, rand_bits(64), rsp);
    check_eq("rom_write_err", 64'h1, 64'(rsp.err));
    clint_reg_test();
    timer_test();

    // Let the debug hold-off expire under observation
    while (dbg_edges < `DMI_DELAY_CYCLES + 8) begin
      @(negedge clk_i);
    end

    // Released gate passes the request straight through
    debug_req_i = 1'b0;
    repeat (3) @(negedge clk_i);
    debug_req_i = 1'b1;
    repeat (3) @(negedge clk_i);

    $display("errors: %0d value, %0d other", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
